// ==== common/rvCorePkg.sv ====
// rvCorePkg: widths, opcode and ALU encodings shared by the RV32I pipeline
package rvCorePkg;

    // ========================================================
    // widths
    // ========================================================
    localparam int kXlen      = 32;
    localparam int kRegAddrW  = 5;
    localparam int kWordAddrW = 30;

    typedef logic [kXlen-1:0]      wordT;
    typedef logic [kRegAddrW-1:0]  regAddrT;
    typedef logic [kWordAddrW-1:0] wordAddrT;

    // ========================================================
    // encodings
    // ========================================================
    // major opcodes, instruction bits 6 to 2
    typedef enum logic [4:0] {
        opLoad   = 5'b00000,
        opOpImm  = 5'b00100,
        opStore  = 5'b01000,
        opOp     = 5'b01100,
        opBranch = 5'b11000,
        opJalr   = 5'b11001,
        opJal    = 5'b11011
    } opcodeE;

    // operation class handed from decode to execute
    typedef enum logic [1:0] {
        aluAdd    = 2'b00,
        aluBranch = 2'b01,
        aluReg    = 2'b10,
        aluImm    = 2'b11
    } aluOpE;

    // ALU operation, coded as {funct7 bit 5, funct3}
    typedef enum logic [3:0] {
        ctrlAdd = 4'b0000,
        ctrlSll = 4'b0001,
        ctrlSlt = 4'b0010,
        ctrlXor = 4'b0100,
        ctrlSrl = 4'b0101,
        ctrlOr  = 4'b0110,
        ctrlAnd = 4'b0111,
        ctrlSub = 4'b1000,
        ctrlSra = 4'b1101
    } aluCtrlE;

    // addi x0, x0, 0
    localparam wordT kNopInst = 32'h0000_0013;

endpackage

// ==== logic/regFile.sv ====
// regFile: 32 x 32-bit integer register file, x0 hardwired to zero
`timescale 1ns/100ps

module regFile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              writeEn,
    input  rvCorePkg::regAddrT writeAddr,
    input  rvCorePkg::wordT   writeData,
    input  rvCorePkg::regAddrT readAddrA,
    input  rvCorePkg::regAddrT readAddrB,
    output rvCorePkg::wordT   readDataA,
    output rvCorePkg::wordT   readDataB
);
    import rvCorePkg::*;

    wordT regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // reads see the registered contents only
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== logic/decodeUnit.sv ====
// decodeUnit: control bits and immediate for the instruction in decode
`timescale 1ns/100ps

module decodeUnit (
    input  rvCorePkg::wordT  inst,
    output logic             isJal,
    output logic             isJalr,
    output logic             isBranch,
    output logic             memRead,
    output logic             memWrite,
    output logic             memToReg,
    output logic             aluSrcImm,
    output logic             regWrite,
    output rvCorePkg::aluOpE aluOp,
    output rvCorePkg::wordT  imm
);
    import rvCorePkg::*;

    opcodeE opcode;

    assign opcode = opcodeE'(inst[6:2]);

    always_comb begin
        isJal     = 1'b0;
        isJalr    = 1'b0;
        isBranch  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        aluOp     = aluAdd;
        imm       = '0;
        case (opcode)
            opLoad: begin
                memRead   = 1'b1;
                memToReg  = 1'b1;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                imm       = {{20{inst[31]}}, inst[31:20]};
            end
            opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            opBranch: begin
                isBranch = 1'b1;
                aluOp    = aluBranch;
                imm      = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            opJal: begin
                isJal    = 1'b1;
                regWrite = 1'b1;
                imm      = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            opJalr: begin
                isJalr   = 1'b1;
                regWrite = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:20]};
            end
            opOpImm: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                aluOp     = aluImm;
                imm       = {{20{inst[31]}}, inst[31:20]};
            end
            opOp: begin
                regWrite = 1'b1;
                aluOp    = aluReg;
            end
            // anything else decodes as a bubble
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/aluUnit.sv ====
// aluUnit: ALU operation select and the execute-stage arithmetic
`timescale 1ns/100ps

module aluUnit (
    input  rvCorePkg::aluOpE aluOp,
    input  logic [2:0]       funct3,
    input  logic             funct7b5,
    input  rvCorePkg::wordT  opA,
    input  rvCorePkg::wordT  opB,
    output rvCorePkg::wordT  result
);
    import rvCorePkg::*;

    aluCtrlE ctrl;

    always_comb begin
        ctrl = ctrlAdd;
        case (aluOp)
            aluAdd:    ctrl = ctrlAdd;
            aluBranch: ctrl = ctrlSub;
            default: begin
                case (funct3)
                    // addi has no subtract form
                    3'b000:  ctrl = (aluOp == aluReg && funct7b5) ? ctrlSub : ctrlAdd;
                    3'b001:  ctrl = ctrlSll;
                    3'b010:  ctrl = ctrlSlt;
                    3'b100:  ctrl = ctrlXor;
                    3'b101:  ctrl = funct7b5 ? ctrlSra : ctrlSrl;
                    3'b110:  ctrl = ctrlOr;
                    3'b111:  ctrl = ctrlAnd;
                    default: ctrl = ctrlAdd;
                endcase
            end
        endcase
    end

    always_comb begin
        case (ctrl)
            ctrlAdd: result = opA + opB;
            ctrlSub: result = opA - opB;
            ctrlSlt: result = {31'b0, $signed(opA) < $signed(opB)};
            ctrlXor: result = opA ^ opB;
            ctrlOr:  result = opA | opB;
            ctrlAnd: result = opA & opB;
            ctrlSll: result = opA << opB[4:0];
            ctrlSrl: result = opA >> opB[4:0];
            ctrlSra: result = $signed(opA) >>> opB[4:0];
            default: result = '0;
        endcase
    end

endmodule

// ==== logic/hazardUnit.sv ====
// hazardUnit: pipeline stall detection and operand forwarding selects
`timescale 1ns/100ps

module hazardUnit (
    input  rvCorePkg::regAddrT decodeRs1,
    input  rvCorePkg::regAddrT decodeRs2,
    input  rvCorePkg::regAddrT exRs1,
    input  rvCorePkg::regAddrT exRs2,
    input  rvCorePkg::regAddrT exRd,
    input  rvCorePkg::regAddrT memRd,
    input  rvCorePkg::regAddrT wbRd,
    input  logic               exRegWrite,
    input  logic               exMemRead,
    input  logic               memRegWrite,
    input  logic               memMemRead,
    input  logic               wbRegWrite,
    input  logic               needsRs,
    output logic               stall,
    output logic [1:0]         fwdDecodeA,
    output logic [1:0]         fwdDecodeB,
    output logic [1:0]         fwdExA,
    output logic [1:0]         fwdExB
);
    import rvCorePkg::*;

    logic loadUse, branchOnEx, branchOnLoad;

    // x0 is never a real producer
    function automatic logic hits(regAddrT rs, regAddrT rd, logic writes);
        return writes && (rs == rd) && (rs != '0);
    endfunction

    // ========================================================
    // stalls
    // ========================================================
    assign loadUse = hits(decodeRs1, exRd, exMemRead) | hits(decodeRs2, exRd, exMemRead);

    // decode compares need the value this cycle
    assign branchOnEx   = needsRs & (hits(decodeRs1, exRd, exRegWrite) |
                                     hits(decodeRs2, exRd, exRegWrite));
    assign branchOnLoad = needsRs & (hits(decodeRs1, memRd, memMemRead) |
                                     hits(decodeRs2, memRd, memMemRead));

    assign stall = loadUse | branchOnEx | branchOnLoad;

    // ========================================================
    // forwarding, 2'b10 memory stage, 2'b01 writeback
    // ========================================================
    assign fwdDecodeA = hits(decodeRs1, memRd, memRegWrite) ? 2'b10 :
                        hits(decodeRs1, wbRd, wbRegWrite)   ? 2'b01 : 2'b00;
    assign fwdDecodeB = hits(decodeRs2, memRd, memRegWrite) ? 2'b10 :
                        hits(decodeRs2, wbRd, wbRegWrite)   ? 2'b01 : 2'b00;
    assign fwdExA     = hits(exRs1, memRd, memRegWrite)     ? 2'b10 :
                        hits(exRs1, wbRd, wbRegWrite)       ? 2'b01 : 2'b00;
    assign fwdExB     = hits(exRs2, memRd, memRegWrite)     ? 2'b10 :
                        hits(exRs2, wbRd, wbRegWrite)       ? 2'b01 : 2'b00;

endmodule

// ==== logic/nextPcUnit.sv ====
// nextPcUnit: program counter with branch and jump resolution in decode
`timescale 1ns/100ps

module nextPcUnit #(
    parameter rvCorePkg::wordT ResetPc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            hold,
    input  logic            stall,
    input  logic            isJal,
    input  logic            isJalr,
    input  logic            isBranch,
    input  logic            branchNe,
    input  rvCorePkg::wordT rs1Val,
    input  rvCorePkg::wordT rs2Val,
    input  rvCorePkg::wordT decodePc,
    input  rvCorePkg::wordT imm,
    output rvCorePkg::wordT pc,
    output logic            redirect
);
    import rvCorePkg::*;

    wordT pcPlus4, branchTarget, jalrSum, nextPc;
    logic taken;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = decodePc + imm;
    assign jalrSum      = rs1Val + imm;

    // beq and bne differ only in funct3 bit 0
    assign taken    = isBranch & ((rs1Val == rs2Val) ^ branchNe);
    assign redirect = ~stall & (isJal | isJalr | taken);

    assign nextPc = stall          ? pc :
                    isJalr         ? {jalrSum[31:1], 1'b0} :
                    (isJal | taken) ? branchTarget : pcPlus4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= ResetPc;
        end else if (!hold) begin
            pc <= nextPc;
        end
    end

endmodule

// ==== rvCore/rvCore.sv ====
// rvCore: five-stage RV32I pipeline with branch resolution in decode
`timescale 1ns/100ps

module rvCore #(
    parameter rvCorePkg::wordT ResetPc = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_n,
    output rvCorePkg::wordAddrT imemAddr,
    input  rvCorePkg::wordT     imemData,
    input  logic                imemStall,
    output logic                dmemRead,
    output logic                dmemWrite,
    output rvCorePkg::wordAddrT dmemAddr,
    output rvCorePkg::wordT     dmemWdata,
    input  rvCorePkg::wordT     dmemRdata,
    input  logic                dmemStall
);
    import rvCorePkg::*;

    // select bit 1 takes the memory stage, bit 0 the writeback stage
    function automatic wordT pickOperand(logic [1:0] sel, wordT memVal, wordT wbVal,
                                         wordT regVal);
        if (sel[1]) begin
            return memVal;
        end
        return sel[0] ? wbVal : regVal;
    endfunction

    // ========================================================
    // fetch and decode
    // ========================================================
    logic    hold, stall, redirect;
    wordT    pc, ifIdInst, ifIdPc;
    regAddrT decRs1, decRs2;
    wordT    rfDataA, rfDataB, decRs1Val, decRs2Val, imm;
    logic    isJal, isJalr, isBranch, memRead, memWrite, memToReg, aluSrcImm, regWrite;
    aluOpE   aluOp;
    logic [1:0] fwdDecodeA, fwdDecodeB, fwdExA, fwdExB;

    // execute
    logic    exRegWrite, exMemRead, exMemWrite, exMemToReg, exAluSrcImm, exIsJump;
    aluOpE   exAluOp;
    wordT    exPc, exRs1Val, exRs2Val, exImm, exOpA, exStoreData, exOpB, aluResult, exResult;
    logic [2:0] exFunct3;
    logic    exFunct7b5;
    regAddrT exRd, exRs1, exRs2;

    // memory and writeback
    logic    memRegWrite, memMemRead, memMemWrite, memMemToReg;
    wordT    memResult, memStoreData;
    regAddrT memRd;
    logic    wbRegWrite, wbMemToReg;
    wordT    wbResult, wbLoadData, wbData;
    regAddrT wbRd;

    // either memory port stalling freezes everything
    assign hold     = imemStall | dmemStall;
    assign imemAddr = pc[31:2];
    assign decRs1   = ifIdInst[19:15];
    assign decRs2   = ifIdInst[24:20];

    nextPcUnit #(.ResetPc(ResetPc)) uNextPc (
        .clk(clk), .rst_n(rst_n), .hold(hold), .stall(stall),
        .isJal(isJal), .isJalr(isJalr), .isBranch(isBranch), .branchNe(ifIdInst[12]),
        .rs1Val(decRs1Val), .rs2Val(decRs2Val), .decodePc(ifIdPc), .imm(imm),
        .pc(pc), .redirect(redirect)
    );

    regFile uRegFile (
        .clk(clk), .rst_n(rst_n), .writeEn(wbRegWrite & ~hold), .writeAddr(wbRd),
        .writeData(wbData), .readAddrA(decRs1), .readAddrB(decRs2),
        .readDataA(rfDataA), .readDataB(rfDataB)
    );

    decodeUnit uDecode (
        .inst(ifIdInst), .isJal(isJal), .isJalr(isJalr), .isBranch(isBranch),
        .memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
        .aluSrcImm(aluSrcImm), .regWrite(regWrite), .aluOp(aluOp), .imm(imm)
    );

    hazardUnit uHazard (
        .decodeRs1(decRs1), .decodeRs2(decRs2), .exRs1(exRs1), .exRs2(exRs2),
        .exRd(exRd), .memRd(memRd), .wbRd(wbRd), .exRegWrite(exRegWrite),
        .exMemRead(exMemRead), .memRegWrite(memRegWrite), .memMemRead(memMemRead),
        .wbRegWrite(wbRegWrite), .needsRs(isBranch | isJalr), .stall(stall),
        .fwdDecodeA(fwdDecodeA), .fwdDecodeB(fwdDecodeB), .fwdExA(fwdExA), .fwdExB(fwdExB)
    );

    assign decRs1Val = pickOperand(fwdDecodeA, memResult, wbData, rfDataA);
    assign decRs2Val = pickOperand(fwdDecodeB, memResult, wbData, rfDataB);

    // ========================================================
    // execute
    // ========================================================
    assign exOpA       = pickOperand(fwdExA, memResult, wbData, exRs1Val);
    assign exStoreData = pickOperand(fwdExB, memResult, wbData, exRs2Val);
    assign exOpB       = exAluSrcImm ? exImm : exStoreData;

    aluUnit uAlu (
        .aluOp(exAluOp), .funct3(exFunct3), .funct7b5(exFunct7b5),
        .opA(exOpA), .opB(exOpB), .result(aluResult)
    );

    // link value of jal and jalr
    assign exResult = exIsJump ? exPc + 32'd4 : aluResult;

    // memory stage and writeback
    assign dmemRead  = memMemRead;
    assign dmemWrite = memMemWrite;
    assign dmemAddr  = memResult[31:2];
    assign dmemWdata = memStoreData;
    assign wbData    = wbMemToReg ? wbLoadData : wbResult;

    // ========================================================
    // pipeline registers
    // ========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifIdInst    <= kNopInst;
            exRegWrite  <= 1'b0;
            exMemRead   <= 1'b0;
            exMemWrite  <= 1'b0;
            exMemToReg  <= 1'b0;
            exAluSrcImm <= 1'b0;
            exIsJump    <= 1'b0;
            exAluOp     <= aluAdd;
            exRd        <= '0;
            exRs1       <= '0;
            exRs2       <= '0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memMemToReg <= 1'b0;
            memRd       <= '0;
            wbRegWrite  <= 1'b0;
            wbMemToReg  <= 1'b0;
            wbRd        <= '0;
        end else if (!hold) begin
            // a taken branch or jump drops the instruction behind it
            if (!stall) begin
                ifIdInst <= redirect ? kNopInst : imemData;
            end
            // hazard stall sends a bubble into execute
            exRegWrite  <= regWrite & ~stall;
            exMemRead   <= memRead & ~stall;
            exMemWrite  <= memWrite & ~stall;
            exMemToReg  <= memToReg & ~stall;
            exAluSrcImm <= aluSrcImm & ~stall;
            exIsJump    <= (isJal | isJalr) & ~stall;
            exAluOp     <= stall ? aluAdd : aluOp;
            exRd        <= ifIdInst[11:7];
            exRs1       <= decRs1;
            exRs2       <= decRs2;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memMemToReg <= exMemToReg;
            memRd       <= exRd;
            wbRegWrite  <= memRegWrite;
            wbMemToReg  <= memMemToReg;
            wbRd        <= memRd;
        end
    end

    // data path registers
    always_ff @(posedge clk) begin
        if (!hold) begin
            if (!stall) begin
                ifIdPc <= pc;
            end
            exPc         <= ifIdPc;
            exRs1Val     <= decRs1Val;
            exRs2Val     <= decRs2Val;
            exImm        <= imm;
            exFunct3     <= ifIdInst[14:12];
            exFunct7b5   <= ifIdInst[30];
            memResult    <= exResult;
            memStoreData <= exStoreData;
            wbResult     <= memResult;
            wbLoadData   <= dmemRdata;
        end
    end

endmodule

// ==== tb/rvCoreTb.sv ====
// rvCoreTb: random-program testbench comparing committed stores with an instruction-level model
`timescale 1ns/100ps

module rvCoreTb;
    import rvCorePkg::*;

    localparam int   kPeriod   = 100;
    localparam int   kProgLen  = 200;
    localparam int   kPrograms = 4;
    localparam int   kBodyLen  = kProgLen - 4;
    localparam wordT kNop      = 32'h0000_0013;

    logic     clk, rst_n, imemStall, dmemStall, dmemRead, dmemWrite;
    wordAddrT imemAddr, dmemAddr;
    wordT     imemData, dmemWdata, dmemRdata;

    wordT prog [256];
    wordT dmem [1024];
    wordT modelMem [1024];
    wordT modelReg [32];
    wordT expAddr [$];
    wordT expData [$];
    int   storeIdx, errors, progNum;
    logic progDone, stallEn;

    rvCore #(.ResetPc(32'h0000_0000)) u_dut (
        .clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .imemData(imemData),
        .imemStall(imemStall), .dmemRead(dmemRead), .dmemWrite(dmemWrite),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
        .dmemStall(dmemStall)
    );

    // combinational memory reads
    assign imemData  = (imemAddr[29:8] == '0) ? prog[imemAddr[7:0]] : kNop;
    assign dmemRdata = dmem[dmemAddr[9:0]];

    always #(kPeriod / 2) clk = ~clk;

    // ============================================================
    // instruction encoding
    // ============================================================
    function automatic wordT encR(logic alt, regAddrT rs2, regAddrT rs1, logic [2:0] f3,
                                  regAddrT rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic wordT encI(logic [11:0] imm, regAddrT rs1, logic [2:0] f3, regAddrT rd,
                                  logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(logic [11:0] imm, regAddrT rs2, regAddrT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic wordT encB(logic [12:0] imm, regAddrT rs2, regAddrT rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic wordT encJ(logic [20:0] imm, regAddrT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ============================================================
    // reference model
    // ============================================================
    function automatic wordT refAlu(logic [2:0] f3, logic alt, wordT a, wordT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd4:    return a ^ b;
            3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic runModel();
        wordT pc, inst, a, b, immI, immS, immB, immJ, addr;
        logic done;
        int   steps;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        expAddr.delete();
        expData.delete();
        for (int r = 0; r < 32; r++) begin
            modelReg[r] = '0;
        end
        while (!done && steps < 4 * kProgLen) begin
            inst  = prog[pc[9:2]];
            a     = modelReg[inst[19:15]];
            b     = modelReg[inst[24:20]];
            immI  = {{20{inst[31]}}, inst[31:20]};
            immS  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            immB  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            immJ  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            steps = steps + 1;
            case (inst[6:0])
                7'b0110011: modelReg[inst[11:7]] = refAlu(inst[14:12], inst[30], a, b);
                7'b0010011: modelReg[inst[11:7]] =
                    refAlu(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, immI);
                7'b0000011: begin
                    addr = a + immI;
                    modelReg[inst[11:7]] = modelMem[addr[11:2]];
                end
                7'b0100011: begin
                    addr = a + immS;
                    modelMem[addr[11:2]] = b;
                    expAddr.push_back({2'b00, addr[31:2]});
                    expData.push_back(b);
                    done = (addr[31:2] == 30'd1023);
                end
                7'b1101111, 7'b1100111: modelReg[inst[11:7]] = pc + 32'd4;
                default: ;
            endcase
            modelReg[0] = '0;
            // next pc
            if (inst[6:0] == 7'b1100011 && ((a == b) ^ inst[12])) begin
                pc = pc + immB;
            end else if (inst[6:0] == 7'b1101111) begin
                pc = pc + immJ;
            end else if (inst[6:0] == 7'b1100111) begin
                pc = (a + immI) & ~32'd1;
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    task automatic buildProgram();
        int         kind, target;
        logic [2:0] f3;
        logic       alt;
        regAddrT    rd, rs1, rs2;
        for (int i = 0; i < 256; i++) begin
            prog[i] = kNop;
        end
        for (int i = 0; i < kBodyLen; i++) begin
            kind   = $urandom % 100;
            rd     = regAddrT'(1 + $urandom % 7);
            rs1    = regAddrT'($urandom % 8);
            rs2    = regAddrT'($urandom % 8);
            target = i + 1 + $urandom % 8;
            if (target > kBodyLen) begin
                target = kBodyLen;
            end
            f3 = 3'($urandom);
            if (f3 == 3'd3) begin
                f3 = 3'd2;
            end
            alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1);
            if (kind < 25) begin
                prog[i] = encR(alt, rs2, rs1, f3, rd);
            end else if (kind < 45 && (f3 == 3'd1 || f3 == 3'd5)) begin
                prog[i] = encI({1'b0, alt, 5'b0, 5'($urandom)}, rs1, f3, rd, 7'b0010011);
            end else if (kind < 45) begin
                prog[i] = encI(12'($urandom), rs1, f3, rd, 7'b0010011);
            end else if (kind < 60) begin
                prog[i] = encI(12'(($urandom % 64) * 4), 5'd0, 3'b010, rd, 7'b0000011);
            end else if (kind < 75) begin
                prog[i] = encS(12'(($urandom % 64) * 4), rs2, 5'd0);
            end else if (kind < 87) begin
                prog[i] = encB(13'((target - i) * 4), rs2, rs1, {2'b00, alt});
            end else if (kind < 93) begin
                prog[i] = encJ(21'((target - i) * 4), rs1);
            end else begin
                // absolute target through x0
                prog[i] = encI(12'(target * 4), 5'd0, 3'b000, rs1, 7'b1100111);
            end
        end
        // x8 = 4092, then the done store to word 1023 and a spin
        prog[kBodyLen]     = encI(12'd2047, 5'd0, 3'b000, 5'd8, 7'b0010011);
        prog[kBodyLen + 1] = encI(12'd2045, 5'd8, 3'b000, 5'd8, 7'b0010011);
        prog[kBodyLen + 2] = encS(12'd0, 5'd1, 5'd8);
        prog[kBodyLen + 3] = encJ(21'd0, 5'd0);
        for (int i = 0; i < 1024; i++) begin
            dmem[i]     = $urandom;
            modelMem[i] = dmem[i];
        end
    endtask

    // ============================================================
    // checking
    // ============================================================
    task automatic checkValue(string name, wordT got, wordT exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic commitStore();
        if (storeIdx >= expAddr.size()) begin
            $display("the DUT committed a store that the reference model never made");
            $display("TEST FAILED");
            $fatal(1, "extra store");
        end
        checkValue("dmemAddr", {2'b00, dmemAddr}, expAddr[storeIdx]);
        checkValue("dmemWdata", dmemWdata, expData[storeIdx]);
        storeIdx = storeIdx + 1;
        if (dmemAddr == 30'd1023) begin
            progDone = 1'b1;
        end
    endtask

    // random stalls on both ports
    always @(posedge clk) begin
        imemStall <= stallEn && ($urandom % 5 == 0);
        dmemStall <= stallEn && ($urandom % 5 == 0);
    end

    // data memory write, counted once when the pipeline advances
    always @(posedge clk) begin
        if (rst_n && dmemWrite && !dmemStall) begin
            dmem[dmemAddr[9:0]] <= dmemWdata;
            if (!imemStall) begin
                commitStore();
            end
        end
    end

    initial begin
        #(kPrograms * (kProgLen * 20 + 10) * kPeriod);
        $display("program %0d never reached its final store", progNum);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(48));
        clk       = 1'b0;
        rst_n     = 1'b0;
        imemStall = 1'b0;
        dmemStall = 1'b0;
        stallEn   = 1'b0;
        progDone  = 1'b0;
        errors    = 0;
        storeIdx  = 0;
        for (progNum = 0; progNum < kPrograms; progNum++) begin
            @(posedge clk);
            rst_n   <= 1'b0;
            stallEn <= 1'b0;
            @(negedge clk);
            buildProgram();
            runModel();
            repeat (4) @(posedge clk);
            checkValue("dmemRead", {31'b0, dmemRead}, 32'd0);
            checkValue("dmemWrite", {31'b0, dmemWrite}, 32'd0);
            checkValue("imemAddr", {2'b00, imemAddr}, 32'd0);
            storeIdx = 0;
            progDone = 1'b0;
            rst_n   <= 1'b1;
            stallEn <= 1'b1;
            wait (progDone);
        end
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/rvCorePkg.sv
logic/regFile.sv
logic/decodeUnit.sv
logic/aluUnit.sv
logic/hazardUnit.sv
logic/nextPcUnit.sv
rvCore/rvCore.sv
tb/rvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module rvCoreTb -f filelist.f
out=$(./obj_dir/VrvCoreTb 2>&1) || true
printf '%s\n' "$out"
# the run passes only if the pass line is present
printf '%s\n' "$out" | grep -qx "TEST PASSED"
echo "simulation passed"
